/* source/i2f_macros.svh */
// width constants shared by every block of the integer to float converter
`ifndef I2F_MACROS_SVH
`define I2F_MACROS_SVH

// integer input and float output share one word width
`define INT_WIDTH 32

// single precision field widths
`define EXP_WIDTH 8 // biased exponent field
`define FRAC_WIDTH 23 // stored fraction without hidden one

// exponent bias for single precision
`define EXP_BIAS 127

`endif

/* source/i2fPkg.sv */
// types that travel between the stages of the integer to float converter
`include "i2f_macros.svh"

package i2fPkg;

	// rounding rule, encoded as on the reference converter
	typedef enum logic [1:0] {
		rmNearestEven = 2'd0, // ties go to even fraction
		rmTowardZero = 2'd1, // plain truncation
		rmTowardPos = 2'd2, // up for positive values
		rmTowardNeg = 2'd3 // up in magnitude for negative values
	} roundMode;

	// conversion request from outside
	typedef struct packed {
		logic [`INT_WIDTH-1:0] value; // two's complement integer
		roundMode mode; // rule for this conversion
	} convRequest;

	// stage one result held in the normalizer register
	typedef struct packed {
		logic sign; // sign of the input
		logic isZero; // input was zero
		logic [`INT_WIDTH-1:0] aligned; // magnitude with leading one at top bit
		logic [`EXP_WIDTH-1:0] expBiased; // exponent before rounding carry
		roundMode mode; // carried along to the rounder
	} normItem;

	// IEEE 754 single precision word
	typedef struct packed {
		logic sign;
		logic [`EXP_WIDTH-1:0] exponent; // biased
		logic [`FRAC_WIDTH-1:0] fraction; // hidden one dropped
	} floatWord;

endpackage

/* source/lzCount32.sv */
// leading-zero counter for a 32-bit magnitude built from a tree of halves
`timescale 1ns/10ps
`include "i2f_macros.svh"

module lzCount32 (
	input logic [`INT_WIDTH-1:0] value,
	output logic [5:0] count, // 32 when value is zero
	output logic allZero
);

	// each level merges pairs of groups from the level below
	// a group reports whether it is all zero and its own zero count
	logic [15:0] zero1; // 2-bit groups
	logic [15:0] cnt1;
	logic [7:0] zero2; // 4-bit groups
	logic [1:0] cnt2 [8];
	logic [3:0] zero3; // 8-bit groups
	logic [2:0] cnt3 [4];
	logic [1:0] zero4; // 16-bit groups
	logic [3:0] cnt4 [2];
	logic [4:0] cnt5; // whole word, valid unless all zero

	// leaf pairs, higher index is more significant
	for (genvar i = 0; i < 16; i++) begin : genPairs
		assign zero1[i] = ~|value[2*i +: 2];
		assign cnt1[i] = ~value[2*i+1]; // one zero if upper bit clear
	end

	// an all-zero upper half adds its width and defers to the lower half
	for (genvar i = 0; i < 8; i++) begin : genQuads
		assign zero2[i] = zero1[2*i+1] & zero1[2*i];
		assign cnt2[i] = zero1[2*i+1] ? {1'b1, cnt1[2*i]} : {1'b0, cnt1[2*i+1]};
	end

	for (genvar i = 0; i < 4; i++) begin : genBytes
		assign zero3[i] = zero2[2*i+1] & zero2[2*i];
		assign cnt3[i] = zero2[2*i+1] ? {1'b1, cnt2[2*i]} : {1'b0, cnt2[2*i+1]};
	end

	for (genvar i = 0; i < 2; i++) begin : genHalves
		assign zero4[i] = zero3[2*i+1] & zero3[2*i];
		assign cnt4[i] = zero3[2*i+1] ? {1'b1, cnt3[2*i]} : {1'b0, cnt3[2*i+1]};
	end

	// root of the tree
	assign allZero = zero4[1] & zero4[0];
	assign cnt5 = zero4[1] ? {1'b1, cnt4[0]} : {1'b0, cnt4[1]};

	// five bits cannot hold 32 so the empty word is patched here
	assign count = allZero ? 6'd32 : {1'b0, cnt5};

endmodule

/* source/i2fNormalize.sv */
// normalizer stage that turns an integer into sign, aligned magnitude and exponent
`timescale 1ns/10ps
`include "i2f_macros.svh"

module i2fNormalize (
	input logic clk,
	input logic rstN,
	input logic reqValid, // single-cycle strobe
	input i2fPkg::convRequest req,
	output logic normValid, // one cycle after reqValid
	output i2fPkg::normItem norm
);

	import i2fPkg::*;

	// exponent of a value whose leading one sits at the top bit
	localparam logic [`EXP_WIDTH-1:0] expTop = `EXP_BIAS + `INT_WIDTH - 1;

	logic negative;
	logic [`INT_WIDTH-1:0] magnitude; // unsigned, so -2^31 fits
	logic [5:0] zeroCount;
	logic allZero;
	logic [`EXP_WIDTH-1:0] expValue;
	normItem nextItem;

	// sign and magnitude
	assign negative = req.value[`INT_WIDTH-1];
	assign magnitude = negative ? (~req.value + 1'b1) : req.value; // -2^31 wraps to 2^31

	lzCount32 lzCount_i (
		.value(magnitude),
		.count(zeroCount),
		.allZero(allZero)
	);

	// every leading zero lowers the exponent by one
	assign expValue = expTop - {{(`EXP_WIDTH - 6){1'b0}}, zeroCount};

	always_comb begin
		nextItem.sign = negative;
		nextItem.isZero = allZero;
		nextItem.aligned = magnitude << zeroCount; // leading one to bit 31
		nextItem.expBiased = allZero ? '0 : expValue; // zero has a zero exponent
		nextItem.mode = req.mode; // passes through untouched
	end

	// stage register, strobe is cleared by reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			normValid <= 1'b0;
		end else begin
			normValid <= reqValid;
		end
	end

	// payload loads only with a request
	always_ff @(posedge clk) begin
		if (reqValid) begin
			norm <= nextItem;
		end
	end

endmodule

/* source/i2fRound.sv */
// rounding stage that applies the rounding rule and packs the single precision word
`timescale 1ns/10ps
`include "i2f_macros.svh"

module i2fRound (
	input logic clk,
	input logic rstN,
	input logic normValid, // strobe from the normalizer
	input i2fPkg::normItem norm,
	output logic resValid, // one cycle after normValid
	output i2fPkg::floatWord res
);

	import i2fPkg::*;

	// bit positions inside the aligned magnitude
	// bit 31 is the hidden one and is dropped
	localparam int fracTop = `INT_WIDTH - 2; // bit 30
	localparam int guardPos = `INT_WIDTH - 1 - `FRAC_WIDTH; // bit 8 is the fraction lsb
	localparam int roundPos = guardPos - 1; // bit 7 is the first bit dropped

	logic [`FRAC_WIDTH-1:0] fraction; // truncated fraction
	logic guardBit;
	logic roundBit;
	logic stickyBit; // any bit below the round bit
	logic increment;
	logic [`FRAC_WIDTH:0] fracSum; // top bit is the mantissa carry
	logic carry;
	logic [`EXP_WIDTH-1:0] expOut;
	floatWord nextRes;

	// split the aligned magnitude
	assign fraction = norm.aligned[fracTop -: `FRAC_WIDTH];
	assign guardBit = norm.aligned[guardPos];
	assign roundBit = norm.aligned[roundPos];
	assign stickyBit = |norm.aligned[roundPos-1:0];

	// rounding decision per mode
	always_comb begin
		increment = 1'b0;
		case (norm.mode)
			rmNearestEven: begin
				increment = roundBit & (guardBit | stickyBit); // above half or tie to odd
			end
			rmTowardZero: begin
				increment = 1'b0; // truncate
			end
			rmTowardPos: begin
				increment = (roundBit | stickyBit) & ~norm.sign;
			end
			rmTowardNeg: begin
				increment = (roundBit | stickyBit) & norm.sign;
			end
		endcase
	end

	// fraction of all ones wraps to zero and carries into the exponent
	assign fracSum = {1'b0, fraction} + {{`FRAC_WIDTH{1'b0}}, increment};
	assign carry = fracSum[`FRAC_WIDTH];
	assign expOut = norm.expBiased + {{(`EXP_WIDTH - 1){1'b0}}, carry};

	// pack the word
	always_comb begin
		if (norm.isZero) begin
			nextRes = '0; // plus zero in every mode
		end else begin
			nextRes.sign = norm.sign;
			nextRes.exponent = expOut;
			nextRes.fraction = fracSum[`FRAC_WIDTH-1:0]; // already zero after a carry
		end
	end

	// output strobe register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			resValid <= 1'b0;
		end else begin
			resValid <= normValid;
		end
	end

	// result loads only with a stage one item
	always_ff @(posedge clk) begin
		if (normValid) begin
			res <= nextRes;
		end
	end

endmodule

/* source/i2fConvert.sv */
// two-stage integer to single precision float converter
`timescale 1ns/10ps

module i2fConvert (
	input logic clk,
	input logic rstN,
	input logic reqValid, // may pulse every cycle
	input i2fPkg::convRequest req,
	output logic resValid, // two cycles after reqValid
	output i2fPkg::floatWord res
);

	import i2fPkg::*;

	// pipeline register between the stages lives in the normalizer
	logic normValid;
	normItem norm;

	// stage one
	i2fNormalize i2fNormalize_i (
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.normValid(normValid),
		.norm(norm)
	);

	// stage two
	i2fRound i2fRound_i (
		.clk(clk),
		.rstN(rstN),
		.normValid(normValid),
		.norm(norm),
		.resValid(resValid),
		.res(res)
	);

endmodule

/* bench/i2fConvert_chk.sv */
// checker bound into the converter that compares each result with an integer model
`timescale 1ns/10ps
`include "i2f_macros.svh"

module i2fConvertChk (
	input logic clk,
	input logic rstN,
	input logic reqValid, // request strobe seen by the DUT
	input i2fPkg::convRequest req,
	input logic resValid, // result strobe from the rounder
	input i2fPkg::floatWord res
);

	import i2fPkg::*;

	int failCount = 0; // read by the testbench

	// expected word from the exact magnitude, plain integer arithmetic
	function automatic floatWord expectedWord(input logic [`INT_WIDTH-1:0] value,
			input roundMode mode);
		floatWord result;
		longint mag;
		longint mant; // significand with hidden one
		longint rest; // part dropped by the shift
		longint half; // weight of the first dropped bit
		int msb;
		int shift;
		logic neg;
		logic up;
		neg = value[`INT_WIDTH-1];
		mag = neg ? (longint'(1) << `INT_WIDTH) - longint'(value) : longint'(value);
		if (mag == 0) begin
			return '0; // plus zero in every mode
		end
		msb = 0;
		while ((longint'(1) << (msb + 1)) <= mag) begin
			msb++; // position of the leading one
		end
		if (msb <= `FRAC_WIDTH) begin
			shift = 0;
			mant = mag << (`FRAC_WIDTH - msb); // exact, nothing dropped
			rest = 0;
			half = 0;
		end else begin
			shift = msb - `FRAC_WIDTH;
			mant = mag >> shift;
			rest = mag - (mant << shift);
			half = longint'(1) << (shift - 1);
		end
		case (mode)
			rmNearestEven: up = (rest != 0) && ((rest > half) || (rest == half && mant % 2 == 1));
			rmTowardZero: up = 1'b0;
			rmTowardPos: up = (rest != 0) && !neg;
			default: up = (rest != 0) && neg; // toward minus infinity
		endcase
		mant = mant + (up ? 1 : 0);
		if (mant == (longint'(1) << (`FRAC_WIDTH + 1))) begin
			mant = mant >> 1; // rounded past a power of two
			msb++;
		end
		result.sign = neg;
		result.exponent = 8'(`EXP_BIAS + msb);
		result.fraction = 23'(mant - (longint'(1) << `FRAC_WIDTH)); // hidden one removed
		return result;
	endfunction

	// every request comes out two cycles later
	reqToRes: assert property (@(posedge clk) disable iff (!rstN) reqValid |-> ##2 resValid)
		else begin
			failCount++;
			$error("Error at %0t: request gave no result two cycles later", $time);
		end

	// and nothing comes out without one
	resFromReq: assert property (@(posedge clk) disable iff (!rstN)
			resValid |-> $past(reqValid, 2))
		else begin
			failCount++;
			$error("Error at %0t: result strobe without a request", $time);
		end

	// zero packs to all zeros whatever the mode
	zeroWord: assert property (@(posedge clk) disable iff (!rstN)
			resValid && $past(req.value, 2) == '0 |-> res == '0)
		else begin
			failCount++;
			$error("Error at %0t: zero input gave %h", $time, res);
		end

	// -2^31 is exact with exponent 158
	mostNegative: assert property (@(posedge clk) disable iff (!rstN)
			resValid && $past(req.value, 2) == 32'h8000_0000 |-> res == {1'b1, 8'd158, 23'd0})
		else begin
			failCount++;
			$error("Error at %0t: most negative input gave %h", $time, res);
		end

	// full comparison with the model
	modelMatch: assert property (@(posedge clk) disable iff (!rstN)
			resValid |-> res == expectedWord($past(req.value, 2), $past(req.mode, 2)))
		else begin
			failCount++;
			$error("Error at %0t: result %h does not match the integer model", $time, res);
		end

endmodule

/* bench/i2fConvertTb.sv */
// testbench driving the integer to float converter with directed and random requests
`timescale 1ns/10ps
`include "i2f_macros.svh"

module i2fConvertTb;

	import i2fPkg::*;

	localparam int clkPeriod = 40; // ns
	localparam int edgeCount = 7; // values swept over all four modes
	localparam int exactCount = 3; // small exact values
	localparam int randomCount = 400;
	localparam int requestCount = edgeCount * 4 + exactCount + randomCount;
	localparam int watchdogCycles = requestCount * 3 + 50;

	// sent back to back, one per mode
	localparam logic [`INT_WIDTH-1:0] edgeValues [edgeCount] = '{
		32'h0000_0000, // zero
		32'h0100_000B, // 16777227, tie just above 2^24
		32'hFEFF_FFF5, // -16777227
		32'h0400_002D, // 2^26 + 45, round and sticky set
		32'hFBFF_FFD3, // its negative
		32'h8000_0000, // most negative
		32'h7FFF_FFFF // mantissa carry in nearest-even
	};

	logic clk;
	logic rstN;
	logic reqValid;
	convRequest req;
	logic resValid;
	floatWord res;

	int sentCount = 0;
	int resultCount = 0;

	i2fConvert i2fConvert_i (
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.resValid(resValid),
		.res(res)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	// one request on the next rising edge, strobe stays high until idle
	task automatic issue(input logic [`INT_WIDTH-1:0] value, input roundMode mode);
		@(posedge clk);
		reqValid <= 1'b1;
		req.value <= value;
		req.mode <= mode;
		sentCount++;
	endtask

	// drop the strobe for a number of cycles
	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			reqValid <= 1'b0;
		end
	endtask

	// counts results as they leave the rounder
	always @(posedge clk) begin
		if (rstN && resValid) begin
			resultCount <= resultCount + 1;
		end
	end

	// stop at the first failed assertion
	always @(posedge clk) begin
		if (i2fConvert_i.i2fConvertChk_i.failCount != 0) begin
			$display("TB FAILED");
			$fatal(1, "the checker reported a failed assertion");
		end
	end

	// watchdog sized from the request count
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("TB FAILED");
		$fatal(1, "timeout, the converter did not return every result in time");
	end

	initial begin
		logic [`INT_WIDTH-1:0] value;
		int shift;
		int gap;
		int seedDummy;
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		seedDummy = $urandom(32'hbb2b_d105); // seeds the generator once
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		// edge values in every mode, back to back
		for (int i = 0; i < edgeCount; i++) begin
			for (int m = 0; m < 4; m++) begin
				issue(edgeValues[i], roundMode'(m));
			end
		end

		// small exact values
		issue(32'd1, rmNearestEven);
		issue(32'hFFFF_FFFF, rmTowardZero); // -1
		issue(32'd16777216, rmNearestEven); // 2^24
		idle(3);

		// random values, modes and gaps
		for (int n = 0; n < randomCount; n++) begin
			value = $urandom;
			shift = $urandom_range(31, 0);
			value = $signed(value) >>> shift; // spread over all magnitudes
			issue(value, roundMode'($urandom_range(3, 0)));
			gap = $urandom_range(2, 0);
			idle(gap); // zero gap keeps the strobe high
		end
		idle(1);

		// wait for the pipeline to drain
		wait (resultCount == sentCount);
		repeat (3) @(posedge clk);
		if (i2fConvert_i.i2fConvertChk_i.failCount == 0 && resultCount == sentCount) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "the run ended with failed checks or extra results after the drain");
		end
	end

endmodule

// checker with the reference model rides inside the DUT
bind i2fConvert i2fConvertChk i2fConvertChk_i (.*);

/* i2fConvert.f */
+incdir+source
source/i2fPkg.sv
source/lzCount32.sv
source/i2fNormalize.sv
source/i2fRound.sv
source/i2fConvert.sv
bench/i2fConvert_chk.sv
bench/i2fConvertTb.sv

/* Bender.yml */
package:
  name: i2fConvert

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/i2fPkg.sv
      - source/lzCount32.sv
      - source/i2fNormalize.sv
      - source/i2fRound.sv
      - source/i2fConvert.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/i2fConvert_chk.sv
      - bench/i2fConvertTb.sv
